//--- common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_ADDR_W 10    // logical and physical address bits
`define CPU_DATA_W 16    // ram word
`define CPU_PAGE_W 6     // offset bits, 64 words per page

`define CPU_NUM_PAGES 16 // physical pages, index is the top address bits
`define CPU_NUM_REGS 16  // chosen by the low bits of the register field

// opcodes, anything else runs as a no-op
`define CPU_OP_JMP 8'd1
`define CPU_OP_RAM2REG 8'd2
`define CPU_OP_REG2RAM 8'd3
`define CPU_OP_NUM2REG 8'd4
`define CPU_OP_PLUS 8'd5
`define CPU_OP_MINUS 8'd6
`define CPU_OP_EXIT 8'd17

`endif

//--- common/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_ADDR_W-1:0] addr_t; // logical or physical
  typedef logic [`CPU_DATA_W-1:0] word_t;

  // first word of each instruction
  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] reg_field;  // low bits pick the register
  } instr_head_t;

  // a fetched word is either the head or the operand
  typedef union packed {
    instr_head_t head;
    word_t       imm;       // address or value operand
  } instr_word_u;

  typedef struct packed {
    addr_t addr;            // physical, no translation
    word_t data;
  } load_req_t;

  typedef struct packed {
    addr_t log_addr;
    addr_t phys_addr;       // after translation
    word_t data;
  } store_evt_t;

  typedef struct packed {
    addr_t log_addr;
  } mmu_req_t;

  typedef struct packed {
    addr_t phys_addr;
    logic  fault;           // no free page left
  } mmu_rsp_t;

endpackage

//--- source/block_ram.sv
`include "cpu_cfg.svh"

module block_ram (
  input  logic           clka,
  input  logic           wr_en,
  input  cpu_pkg::addr_t wr_addr,
  input  cpu_pkg::word_t wr_data,
  input  logic           rd_en,
  input  cpu_pkg::addr_t rd_addr,
  output cpu_pkg::word_t rd_data
);
  import cpu_pkg::*;

  localparam int DEPTH = 1 << `CPU_ADDR_W;

  word_t mem [DEPTH];

  always_ff @(posedge clka) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clka) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- mmu/mmu.sv
`include "cpu_cfg.svh"

module mmu (
  input  logic              clka,
  input  logic              rst,
  input  logic              start,
  input  logic              mmu_req_valid,
  input  cpu_pkg::mmu_req_t mmu_req,
  output logic              mmu_done,
  output cpu_pkg::mmu_rsp_t mmu_rsp
);
  import cpu_pkg::*;

  localparam int PIDX_W = `CPU_ADDR_W - `CPU_PAGE_W;
  localparam int LPAGES = 1 << PIDX_W;

  logic [LPAGES-1:0]      map_valid;
  logic [PIDX_W-1:0]      map_page [LPAGES];  // physical page per logical page
  logic [PIDX_W:0]        next_free;          // one extra bit to see exhaustion
  logic [PIDX_W-1:0]      log_page;
  logic [`CPU_PAGE_W-1:0] page_off;
  logic                   hit;
  logic                   room;
  logic                   alloc;
  logic [PIDX_W-1:0]      phys_page;

  assign log_page  = mmu_req.log_addr[`CPU_ADDR_W-1:`CPU_PAGE_W];
  assign page_off  = mmu_req.log_addr[`CPU_PAGE_W-1:0];
  assign hit       = map_valid[log_page];
  assign room      = next_free < (PIDX_W+1)'(`CPU_NUM_PAGES);
  assign alloc     = mmu_req_valid && !hit && room;   // first touch of a page
  assign phys_page = hit ? map_page[log_page] : next_free[PIDX_W-1:0];

  always_ff @(posedge clka) begin
    if (!rst || start) begin
      map_valid   <= LPAGES'(1);    // only logical page 0 mapped
      map_page[0] <= '0;
      next_free   <= (PIDX_W+1)'(1);
      mmu_done    <= 1'b0;
    end else begin
      mmu_done <= mmu_req_valid;
      if (alloc) begin
        map_valid[log_page] <= 1'b1;
        map_page[log_page]  <= phys_page;
        next_free           <= next_free + 1'b1;
      end
    end
  end

  // offset passes through unchanged
  always_ff @(posedge clka) begin
    if (mmu_req_valid) begin
      mmu_rsp.phys_addr <= {phys_page, page_off};
      mmu_rsp.fault     <= !hit && !room;
    end
  end

endmodule

//--- core/cpu_seq.sv
`include "cpu_cfg.svh"

module cpu_seq (
  input  logic                clka,
  input  logic                rst,
  input  logic                start,
  input  logic                mmu_done,
  input  cpu_pkg::mmu_rsp_t   mmu_rsp,
  input  cpu_pkg::word_t      rd_data,
  output logic                mmu_req_valid,
  output cpu_pkg::mmu_req_t   mmu_req,
  output logic                rd_en,
  output cpu_pkg::addr_t      rd_addr,
  output logic                wr_en,
  output cpu_pkg::addr_t      wr_addr,
  output cpu_pkg::word_t      wr_data,
  output logic                busy,
  output logic                halted,
  output logic                fault,
  output logic                store_valid,
  output cpu_pkg::store_evt_t store
);
  import cpu_pkg::*;

  localparam int REG_SEL_W = $clog2(`CPU_NUM_REGS);

  localparam logic [3:0] ST_IDLE     = 4'd0;
  localparam logic [3:0] ST_HEAD_REQ = 4'd1;
  localparam logic [3:0] ST_HEAD_XLT = 4'd2;  // translated, read issued
  localparam logic [3:0] ST_HEAD_RD  = 4'd3;
  localparam logic [3:0] ST_OPND_REQ = 4'd4;
  localparam logic [3:0] ST_OPND_XLT = 4'd5;
  localparam logic [3:0] ST_OPND_RD  = 4'd6;
  localparam logic [3:0] ST_EXEC     = 4'd7;
  localparam logic [3:0] ST_DATA_REQ = 4'd8;
  localparam logic [3:0] ST_DATA_XLT = 4'd9;  // ram2reg read or reg2ram write
  localparam logic [3:0] ST_DATA_RD  = 4'd10;

  logic [3:0]           state;
  addr_t                pc;          // next word to fetch
  instr_head_t          head;
  word_t                imm;
  instr_word_u          fetch_word;
  word_t                regs [`CPU_NUM_REGS];
  logic [REG_SEL_W-1:0] reg_idx;
  word_t                reg_val;
  logic                 reg_we;
  word_t                reg_wd;
  addr_t                data_addr;
  logic                 xlt_ok;
  logic                 xlt_fault;

  assign fetch_word = rd_data;
  assign reg_idx    = head.reg_field[REG_SEL_W-1:0];
  assign reg_val    = regs[reg_idx];
  assign data_addr  = imm[`CPU_ADDR_W-1:0];
  assign xlt_ok     = mmu_done && !mmu_rsp.fault;
  assign xlt_fault  = mmu_done && mmu_rsp.fault;

  always_comb begin
    mmu_req_valid = (state == ST_HEAD_REQ) || (state == ST_OPND_REQ) ||
                    (state == ST_DATA_REQ);
    mmu_req.log_addr = (state == ST_DATA_REQ) ? data_addr : pc;
    rd_en = xlt_ok && ((state == ST_HEAD_XLT) || (state == ST_OPND_XLT) ||
            (state == ST_DATA_XLT && head.opcode == `CPU_OP_RAM2REG));
    wr_en = xlt_ok && (state == ST_DATA_XLT) && (head.opcode == `CPU_OP_REG2RAM);
  end

  assign rd_addr     = mmu_rsp.phys_addr; // straight from the translation
  assign wr_addr     = mmu_rsp.phys_addr;
  assign wr_data     = reg_val;
  assign store_valid = wr_en;
  assign store       = '{log_addr: data_addr, phys_addr: mmu_rsp.phys_addr, data: reg_val};

  // register file write, arithmetic wraps
  always_comb begin
    reg_we = 1'b0;
    reg_wd = imm;
    if (state == ST_DATA_RD) begin
      reg_we = 1'b1;
      reg_wd = rd_data;
    end else if (state == ST_EXEC) begin
      case (head.opcode)
        `CPU_OP_NUM2REG: reg_we = 1'b1;
        `CPU_OP_PLUS: begin
          reg_we = 1'b1;
          reg_wd = reg_val + imm;
        end
        `CPU_OP_MINUS: begin
          reg_we = 1'b1;
          reg_wd = reg_val - imm;
        end
        default: reg_we = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (start) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;                    // each run starts from zero
      end
    end else if (reg_we) begin
      regs[reg_idx] <= reg_wd;
    end
  end

  always_ff @(posedge clka) begin
    if (state == ST_HEAD_RD) begin
      head <= fetch_word.head;
    end
    if (state == ST_OPND_RD) begin
      imm <= fetch_word.imm;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state  <= ST_IDLE;
      pc     <= '0;
      busy   <= 1'b0;
      halted <= 1'b0;
      fault  <= 1'b0;
    end else if (start) begin
      state  <= ST_HEAD_REQ;
      pc     <= '0;
      busy   <= 1'b1;
      halted <= 1'b0;
      fault  <= 1'b0;
    end else begin
      case (state)
        ST_HEAD_REQ: state <= ST_HEAD_XLT;
        ST_OPND_REQ: state <= ST_OPND_XLT;
        ST_DATA_REQ: state <= ST_DATA_XLT;
        ST_HEAD_XLT, ST_OPND_XLT, ST_DATA_XLT: begin
          if (xlt_fault) begin
            state  <= ST_IDLE;            // out of pages
            busy   <= 1'b0;
            halted <= 1'b1;
            fault  <= 1'b1;
          end else if (mmu_done) begin
            case (state)
              ST_HEAD_XLT: state <= ST_HEAD_RD;
              ST_OPND_XLT: state <= ST_OPND_RD;
              default: state <= (head.opcode == `CPU_OP_RAM2REG) ? ST_DATA_RD : ST_HEAD_REQ;
            endcase
          end
        end
        ST_HEAD_RD: begin
          pc    <= pc + 1'b1;
          state <= ST_OPND_REQ;
        end
        ST_OPND_RD: begin
          pc    <= pc + 1'b1;
          state <= ST_EXEC;
        end
        ST_EXEC: begin
          case (head.opcode)
            `CPU_OP_JMP: begin
              pc    <= data_addr;
              state <= ST_HEAD_REQ;
            end
            `CPU_OP_RAM2REG, `CPU_OP_REG2RAM: state <= ST_DATA_REQ;
            `CPU_OP_EXIT: begin
              state  <= ST_IDLE;
              busy   <= 1'b0;
              halted <= 1'b1;
            end
            default: state <= ST_HEAD_REQ; // register ops and no-ops
          endcase
        end
        ST_DATA_RD: state <= ST_HEAD_REQ;
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- source/cpu_top.sv
module cpu_top (
  input  logic                clka,
  input  logic                rst,
  input  logic                load_en,
  input  cpu_pkg::load_req_t  load,
  input  logic                start,
  output logic                busy,
  output logic                halted,
  output logic                fault,
  output logic                store_valid,
  output cpu_pkg::store_evt_t store
);
  import cpu_pkg::*;

  logic     mmu_req_valid;
  mmu_req_t mmu_req;
  logic     mmu_done;
  mmu_rsp_t mmu_rsp;
  logic     rd_en;
  addr_t    rd_addr;
  word_t    rd_data;
  logic     seq_wr_en;
  addr_t    seq_wr_addr;
  word_t    seq_wr_data;
  logic     ram_wr_en;
  addr_t    ram_wr_addr;
  word_t    ram_wr_data;

  // load port owns the write port while the core is idle
  assign ram_wr_en   = busy ? seq_wr_en : load_en;
  assign ram_wr_addr = busy ? seq_wr_addr : load.addr;
  assign ram_wr_data = busy ? seq_wr_data : load.data;

  cpu_seq u_cpu_seq (
    .clka          (clka),
    .rst           (rst),
    .start         (start),
    .mmu_done      (mmu_done),
    .mmu_rsp       (mmu_rsp),
    .rd_data       (rd_data),
    .mmu_req_valid (mmu_req_valid),
    .mmu_req       (mmu_req),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .wr_en         (seq_wr_en),
    .wr_addr       (seq_wr_addr),
    .wr_data       (seq_wr_data),
    .busy          (busy),
    .halted        (halted),
    .fault         (fault),
    .store_valid   (store_valid),
    .store         (store)
  );

  mmu u_mmu (
    .clka          (clka),
    .rst           (rst),
    .start         (start),
    .mmu_req_valid (mmu_req_valid),
    .mmu_req       (mmu_req),
    .mmu_done      (mmu_done),
    .mmu_rsp       (mmu_rsp)
  );

  block_ram u_block_ram (
    .clka    (clka),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- sim/cpu_chk.sv
module cpu_chk (
  input logic clka,
  input logic rst,
  input logic busy,
  input logic halted,
  input logic store_valid,
  input logic mmu_req_valid,
  input logic mmu_done
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0; // watched by the testbench

  // mmu answers on the very next edge
  a_mmu_next: assert property (@(posedge clka) disable iff (!rst)
    mmu_req_valid |=> mmu_done)
    else begin
      $error("mmu_done missing one cycle after mmu_req_valid");
      fail_count++;
    end

  a_mmu_only: assert property (@(posedge clka) disable iff (!rst)
    mmu_done |-> $past(mmu_req_valid))
    else begin
      $error("mmu_done without a request in the previous cycle");
      fail_count++;
    end

  a_no_store_halted: assert property (@(posedge clka) disable iff (!rst)
    !(store_valid && halted))
    else begin
      $error("store_valid while halted");
      fail_count++;
    end

  a_busy_halted: assert property (@(posedge clka) disable iff (!rst)
    !(busy && halted))
    else begin
      $error("busy and halted high together");
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge clka)
    !rst |=> !busy && !halted && !store_valid)
    else begin
      $error("outputs not idle after reset");
      fail_count++;
    end

endmodule

// the mmu request and done wires are the mmu's own ports
bind cpu_top cpu_chk u_cpu_chk (
  .clka          (clka),
  .rst           (rst),
  .busy          (busy),
  .halted        (halted),
  .store_valid   (store_valid),
  .mmu_req_valid (mmu_req_valid),
  .mmu_done      (mmu_done)
);

//--- sim/cpu_tb.sv
`include "cpu_cfg.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int MEM_WORDS    = 1 << `CPU_ADDR_W;
  localparam int PIDX_W       = `CPU_ADDR_W - `CPU_PAGE_W;
  localparam int LPAGES       = 1 << PIDX_W;
  localparam int HALT_TIMEOUT = 2000; // cycles
  localparam int REF_STEPS    = 4096; // instructions

  logic       clka = 1'b0;
  logic       rst;
  logic       load_en;
  load_req_t  load;
  logic       start;
  logic       busy;
  logic       halted;
  logic       fault;
  logic       store_valid;
  store_evt_t store;

  integer            seed = 11240;
  string             test_name;
  word_t             model_mem [MEM_WORDS]; // physical image loaded into the ram
  word_t             ref_mem [MEM_WORDS];
  logic              ref_valid [LPAGES];
  logic [PIDX_W-1:0] ref_page [LPAGES];
  int                ref_next;
  store_evt_t        exp_stores [$];
  logic              exp_fault;
  int                store_count;

  always #50 clka = ~clka;

  cpu_top u_cpu_top (
    .clka        (clka),
    .rst         (rst),
    .load_en     (load_en),
    .load        (load),
    .start       (start),
    .busy        (busy),
    .halted      (halted),
    .fault       (fault),
    .store_valid (store_valid),
    .store       (store)
  );

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_store(input string name, input store_evt_t exp, input store_evt_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s store %0d: expected %h/%h/%h actual %h/%h/%h", name,
               store_count, exp.log_addr, exp.phys_addr, exp.data,
               act.log_addr, act.phys_addr, act.data);
      abort_run();
    end
  endtask

  task automatic check_halt(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s fault: expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s busy: expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("CHECK FAILED %s store count: expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // first touch maps a page to the next free one, sets exp_fault when none is left
  function automatic logic translate(input addr_t la, output addr_t pa);
    logic [PIDX_W-1:0] lp;
    lp = la[`CPU_ADDR_W-1:`CPU_PAGE_W];
    pa = '0;
    if (!ref_valid[lp]) begin
      if (ref_next >= `CPU_NUM_PAGES) begin
        exp_fault = 1'b1;
        return 1'b1;
      end
      ref_valid[lp] = 1'b1;
      ref_page[lp]  = ref_next[PIDX_W-1:0];
      ref_next++;
    end
    pa = {ref_page[lp], la[`CPU_PAGE_W-1:0]};
    return 1'b0;
  endfunction

  // runs the program in model_mem, fills exp_stores and exp_fault
  function automatic void run_reference();
    word_t                           regs [`CPU_NUM_REGS];
    instr_word_u                     hw;
    instr_word_u                     ow;
    addr_t                           pc;
    addr_t                           pa;
    addr_t                           la;
    logic [$clog2(`CPU_NUM_REGS)-1:0] ri;
    store_evt_t                      ev;
    exp_stores.delete();
    exp_fault = 1'b0;
    foreach (ref_mem[i]) ref_mem[i] = model_mem[i];
    foreach (ref_valid[i]) ref_valid[i] = (i == 0);
    foreach (ref_page[i]) ref_page[i] = '0;
    foreach (regs[i]) regs[i] = '0;
    ref_next = 1;
    pc = '0;
    for (int step = 0; step < REF_STEPS; step++) begin
      if (translate(pc, pa)) break;
      hw = ref_mem[pa];
      pc = pc + 1'b1;
      if (translate(pc, pa)) break;
      ow = ref_mem[pa];
      pc = pc + 1'b1;
      ri = hw.head.reg_field[$clog2(`CPU_NUM_REGS)-1:0];
      la = ow.imm[`CPU_ADDR_W-1:0];
      if (hw.head.opcode == `CPU_OP_EXIT) break;
      case (hw.head.opcode)
        `CPU_OP_JMP: pc = la;
        `CPU_OP_NUM2REG: regs[ri] = ow.imm;
        `CPU_OP_PLUS: regs[ri] = regs[ri] + ow.imm;  // wraps at 16 bits
        `CPU_OP_MINUS: regs[ri] = regs[ri] - ow.imm;
        `CPU_OP_RAM2REG: begin
          if (translate(la, pa)) break;
          regs[ri] = ref_mem[pa];
        end
        `CPU_OP_REG2RAM: begin
          if (translate(la, pa)) break;
          ref_mem[pa] = regs[ri];
          ev = '{log_addr: la, phys_addr: pa, data: regs[ri]};
          exp_stores.push_back(ev);
        end
        default: ;                                  // unknown opcodes do nothing
      endcase
    end
  endfunction

  function automatic void fill_pattern(input word_t salt);
    for (int a = 0; a < MEM_WORDS; a++) begin
      model_mem[a] = word_t'(a * 40503) ^ salt;   // every address bit counts
    end
  endfunction

  function automatic void put_instr(input int slot, input logic [7:0] op,
                                    input logic [7:0] rf, input word_t imm);
    instr_head_t h;
    h = '{opcode: op, reg_field: rf};
    model_mem[2 * slot]     = h;
    model_mem[2 * slot + 1] = imm;
  endfunction

  // 19 random kept instructions, then exit; jumps only go forward
  task automatic build_random();
    logic [7:0] op;
    word_t      imm;
    int         t;
    fill_pattern(word_t'($random(seed)));
    for (int i = 0; i < 19; i++) begin
      imm = word_t'($random(seed));
      case ($unsigned($random(seed)) % 6)
        0: begin
          op  = `CPU_OP_JMP;
          t   = i + 1 + $unsigned($random(seed)) % (19 - i);
          imm = word_t'(2 * t);
        end
        1: op = `CPU_OP_RAM2REG;
        2: op = `CPU_OP_REG2RAM;
        3: op = `CPU_OP_NUM2REG;
        4: op = `CPU_OP_PLUS;
        default: op = `CPU_OP_MINUS;
      endcase
      if (op == `CPU_OP_RAM2REG || op == `CPU_OP_REG2RAM) begin
        imm[`CPU_ADDR_W-1:`CPU_PAGE_W] = PIDX_W'(1 + $unsigned($random(seed)) % 15);
      end
      put_instr(i, op, 8'($random(seed)), imm);
    end
    put_instr(19, `CPU_OP_EXIT, 8'h00, 16'h0000);
  endtask

  task automatic load_memory();
    for (int a = 0; a < MEM_WORDS; a++) begin
      @(posedge clka);
      load_en <= 1'b1;
      load    <= '{addr: addr_t'(a), data: model_mem[a]};
    end
    @(posedge clka);
    load_en <= 1'b0;
  endtask

  task automatic run_program(input string name);
    int cycles;
    test_name = name;
    load_memory();
    run_reference();
    store_count = 0;
    @(posedge clka);
    start <= 1'b1;
    @(posedge clka);
    start <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clka);
      cycles++;
      if (cycles > HALT_TIMEOUT) begin
        $display("timeout: %s did not halt within %0d cycles", name, HALT_TIMEOUT);
        abort_run();
      end
      if (halted !== 1'b1) begin
        check_busy(name, 1'b1, busy);     // running since the cycle after start
      end
    end while (halted !== 1'b1);
    check_busy(name, 1'b0, busy);
    check_halt(name, exp_fault, fault);
    check_count(name, exp_stores.size(), store_count);
  endtask

  // compare every store pulse against the reference list
  always @(negedge clka) begin
    if (rst && store_valid) begin
      if (store_count >= exp_stores.size()) begin
        $display("unexpected extra store in %s at logical %h", test_name, store.log_addr);
        abort_run();
      end else begin
        check_store(test_name, exp_stores[store_count], store);
        store_count++;
      end
    end
  end

  // a failed bound assertion stops the run at once
  always @(negedge clka) begin
    if (u_cpu_top.u_cpu_chk.fail_count != 0) begin
      $display("bound assertion failed during %s", test_name);
      abort_run();
    end
  end

  initial begin
    rst     = 1'b0;
    load_en = 1'b0;
    load    = '0;
    start   = 1'b0;
    repeat (16) @(posedge clka);
    rst <= 1'b1;
    @(posedge clka);

    fill_pattern(16'h1234);
    put_instr(0, `CPU_OP_NUM2REG, 8'h21, 16'd100);   // upper register bits ignored
    put_instr(1, `CPU_OP_PLUS, 8'h01, 16'h7fff);
    put_instr(2, `CPU_OP_REG2RAM, 8'h01, 16'h00c0);
    put_instr(3, `CPU_OP_NUM2REG, 8'h02, 16'd5);
    put_instr(4, `CPU_OP_MINUS, 8'h02, 16'd9);       // below zero
    put_instr(5, `CPU_OP_REG2RAM, 8'h02, 16'h00c1);
    put_instr(6, `CPU_OP_PLUS, 8'h01, 16'hffff);
    put_instr(7, `CPU_OP_REG2RAM, 8'h01, 16'h00c2);
    put_instr(8, `CPU_OP_MINUS, 8'h03, 16'd1);
    put_instr(9, `CPU_OP_REG2RAM, 8'h03, 16'h00c3);
    put_instr(10, `CPU_OP_EXIT, 8'h00, 16'h0000);
    run_program("arith_wrap");

    fill_pattern(16'h5a5a);
    put_instr(0, `CPU_OP_NUM2REG, 8'h07, 16'h1357);
    put_instr(1, `CPU_OP_REG2RAM, 8'h07, 16'hfcc5);  // page 3, upper bits unused
    put_instr(2, `CPU_OP_PLUS, 8'h07, 16'd1);
    put_instr(3, `CPU_OP_REG2RAM, 8'h07, 16'h01c9);  // page 7
    put_instr(4, `CPU_OP_REG2RAM, 8'h07, 16'h00ca);  // page 3 again
    put_instr(5, `CPU_OP_REG2RAM, 8'h07, 16'h017f);  // page 5
    put_instr(6, `CPU_OP_EXIT, 8'h00, 16'h0000);
    run_program("page_order");

    fill_pattern(16'hc3c3);
    put_instr(0, `CPU_OP_RAM2REG, 8'h04, 16'h0107);
    put_instr(1, `CPU_OP_REG2RAM, 8'h04, 16'h02c0);
    put_instr(2, `CPU_OP_NUM2REG, 8'h05, 16'hbeef);
    put_instr(3, `CPU_OP_REG2RAM, 8'h05, 16'h0145);
    put_instr(4, `CPU_OP_RAM2REG, 8'h06, 16'h0145);  // read back own store
    put_instr(5, `CPU_OP_REG2RAM, 8'h06, 16'h0146);
    put_instr(6, `CPU_OP_EXIT, 8'h00, 16'h0000);
    run_program("load_roundtrip");

    fill_pattern(16'h0ff0);
    put_instr(0, `CPU_OP_NUM2REG, 8'h01, 16'h0055);
    put_instr(1, `CPU_OP_JMP, 8'h00, 16'd6);
    put_instr(2, `CPU_OP_REG2RAM, 8'h01, 16'h0080);  // skipped
    put_instr(3, `CPU_OP_REG2RAM, 8'h01, 16'h00c0);
    put_instr(4, `CPU_OP_EXIT, 8'h00, 16'h0000);
    run_program("jmp_skip");

    // logical space has as many pages as physical, so the table fills exactly
    fill_pattern(16'h0f0f);
    put_instr(0, `CPU_OP_NUM2REG, 8'h00, 16'h00a5);
    for (int p = 1; p < LPAGES; p++) begin
      put_instr(p, `CPU_OP_REG2RAM, 8'h00, word_t'((p << `CPU_PAGE_W) + p));
    end
    put_instr(LPAGES, `CPU_OP_REG2RAM, 8'h00, 16'h03ff);
    put_instr(LPAGES + 1, `CPU_OP_EXIT, 8'h00, 16'h0000);
    run_program("page_exhaust");

    for (int n = 0; n < 10; n++) begin
      build_random();
      run_program($sformatf("random_%0d", n));
    end

    if (u_cpu_top.u_cpu_chk.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("assertion failures: %0d", u_cpu_top.u_cpu_chk.fail_count);
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
common/cpu_pkg.sv
source/block_ram.sv
mmu/mmu.sv
core/cpu_seq.sv
source/cpu_top.sv
sim/cpu_chk.sv
sim/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_paged

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - source/block_ram.sv
      - mmu/mmu.sv
      - core/cpu_seq.sv
      - source/cpu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/cpu_chk.sv
      - sim/cpu_tb.sv
